// ==== logic/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ---------------------------------------------------------------------
// base opcodes, instr[6:0]
// ---------------------------------------------------------------------

`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011  // register-immediate alu ops
`define RV_OP_REG     7'b0110011  // register-register alu ops

// ---------------------------------------------------------------------
// memory map
// ---------------------------------------------------------------------

`define RV_RESET_PC   32'h0000_0000  // first fetch after reset

`define RV_IMEM_WORDS 1024  // 4 KiB program store
`define RV_DMEM_WORDS 512   // 2 KiB data store

`endif

// ==== logic/rv_pkg.sv ====
package rv_pkg;

    // -----------------------------------------------------------------
    // basic vectors
    // -----------------------------------------------------------------

    typedef logic [31:0] word_t;       // data, pc, instruction
    typedef logic [4:0]  reg_addr_t;   // x0..x31
    typedef logic [29:0] word_addr_t;  // byte address without [1:0]

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B  // lui passes the immediate through
    } alu_op_e;

    typedef enum logic [1:0] {
        BYTE, HALF, WORD
    } mem_size_e;

    // -----------------------------------------------------------------
    // decoded control and memory traffic
    // -----------------------------------------------------------------

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        mem_size_e   mem_size;
        logic        mem_unsigned;  // lbu, lhu
        logic        a_is_pc;
        logic        b_is_imm;
        alu_op_e     alu_op;
        logic        is_branch;
        logic [2:0]  branch_funct;  // funct3 of the branch
        logic        is_jal;
        logic        is_jalr;
        logic        wb_link;       // rd gets pc+4
    } ctrl_t;

    typedef struct packed {
        logic        write;
        word_addr_t  waddr;
        logic [3:0]  byte_en;
        word_t       wdata;    // already placed in its lanes
    } dmem_req_t;

    typedef struct packed {
        logic        valid;
        word_t       addr;     // word aligned byte address
        logic [3:0]  byte_en;
        word_t       wdata;
    } store_rpt_t;

endpackage

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode import rv_pkg::*; (
    input  word_t     instr_i,
    output ctrl_t     ctrl_o,
    output word_t     imm_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output reg_addr_t rd_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;  // funct7[5], sub and sra

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return sub_sra ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    function automatic mem_size_e size_from_funct(input logic [1:0] f);
        case (f)
            2'b00:   return BYTE;
            2'b01:   return HALF;
            default: return WORD;
        endcase
    endfunction

    always_comb begin
        ctrl_o = '0;  // anything unlisted retires as a no-op
        imm_o  = '0;
        case (opcode)
            `RV_OP_LUI: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.alu_op    = PASS_B;
                imm_o            = {instr_i[31:12], 12'b0};
            end
            `RV_OP_AUIPC: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.a_is_pc   = 1'b1;
                ctrl_o.b_is_imm  = 1'b1;
                imm_o            = {instr_i[31:12], 12'b0};
            end
            `RV_OP_JAL: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.is_jal    = 1'b1;
                ctrl_o.wb_link   = 1'b1;
                imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            `RV_OP_JALR: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.is_jalr   = 1'b1;
                ctrl_o.wb_link   = 1'b1;
                imm_o            = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            `RV_OP_BRANCH: begin
                ctrl_o.is_branch    = 1'b1;  // rs1 vs rs2 in the comparator
                ctrl_o.branch_funct = funct3;
                imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            `RV_OP_LOAD: begin
                ctrl_o.reg_write    = 1'b1;
                ctrl_o.mem_read     = 1'b1;
                ctrl_o.b_is_imm     = 1'b1;
                ctrl_o.mem_size     = size_from_funct(funct3[1:0]);
                ctrl_o.mem_unsigned = funct3[2];
                imm_o               = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            `RV_OP_STORE: begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.mem_size  = size_from_funct(funct3[1:0]);
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            `RV_OP_IMM: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.alu_op    = alu_from_funct(funct3, (funct3 == 3'b101) && alt);
                imm_o            = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            `RV_OP_REG: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = alu_from_funct(funct3, alt);
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic      clk,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [31:1];  // x0 has no storage

    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    always_ff @(posedge clk) begin
        if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // a write aimed at x0 must not show up on either read port afterwards
    a_x0_stays_zero: assert property (@(posedge clk)
        (we_i && (rd_i == '0)) |=>
            ((rs1_i != '0) || (rdata1_o == '0)) && ((rs2_i != '0) || (rdata2_o == '0)));

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  alu_op_e    op_i,
    input  word_t      a_i,
    input  word_t      b_i,
    input  logic [2:0] funct_i,
    output word_t      result_o,
    output logic       taken_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            SLL:     result_o = a_i << b_i[4:0];
            SLT:     result_o = {31'b0, lt_s};
            SLTU:    result_o = {31'b0, lt_u};
            XOR:     result_o = a_i ^ b_i;
            SRL:     result_o = a_i >> b_i[4:0];
            SRA:     result_o = $signed(a_i) >>> b_i[4:0];
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            PASS_B:  result_o = b_i;
            default: result_o = '0;
        endcase
    end

    // ---------------------------------------------------------------------
    // branch comparator
    // ---------------------------------------------------------------------

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (funct_i)
            3'b000:  taken_o = eq;     // beq
            3'b001:  taken_o = !eq;    // bne
            3'b100:  taken_o = lt_s;   // blt
            3'b101:  taken_o = !lt_s;  // bge
            3'b110:  taken_o = lt_u;   // bltu
            3'b111:  taken_o = !lt_u;  // bgeu
            default: taken_o = 1'b0;
        endcase
    end

endmodule

// ==== logic/rv_mem.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_mem import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       imem_we_i,
    input  word_t      imem_waddr_i,  // byte address
    input  word_t      imem_wdata_i,
    input  word_t      imem_addr_i,   // byte address
    output word_t      imem_rdata_o,
    input  dmem_req_t  dmem_i,
    output word_t      dmem_rdata_o,
    output store_rpt_t store_o
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    word_t imem [`RV_IMEM_WORDS];
    word_t dmem [`RV_DMEM_WORDS];

    logic       rpt_valid;
    word_t      rpt_addr;
    logic [3:0] rpt_byte_en;
    word_t      rpt_wdata;

    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_waddr_i[IMEM_AW+1:2]] <= imem_wdata_i;
        end
    end

    assign imem_rdata_o = imem[imem_addr_i[IMEM_AW+1:2]];
    assign dmem_rdata_o = dmem[dmem_i.waddr[DMEM_AW-1:0]];

    always_ff @(posedge clk) begin
        if (dmem_i.write) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_i.byte_en[i]) begin
                    dmem[dmem_i.waddr[DMEM_AW-1:0]][8*i +: 8] <= dmem_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // ---------------------------------------------------------------------
    // store report one cycle behind the write
    // ---------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            rpt_valid <= 1'b0;
        end else begin
            rpt_valid <= dmem_i.write;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_i.write) begin
            rpt_addr    <= {dmem_i.waddr, 2'b00};
            rpt_byte_en <= dmem_i.byte_en;
            rpt_wdata   <= dmem_i.wdata;
        end
    end

    assign store_o = '{valid: rpt_valid, addr: rpt_addr, byte_en: rpt_byte_en, wdata: rpt_wdata};

    a_store_has_lanes: assert property (@(posedge clk) disable iff (reset)
        dmem_i.write |-> (dmem_i.byte_en != 4'b0000));

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr_o,
    input  word_t     imem_data_i,
    output dmem_req_t dmem_o,
    input  word_t     dmem_rdata_i,
    output word_t     retire_pc_o
);

    word_t      pc;
    word_t      pc_plus4;
    word_t      pc_next;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    word_t      byte_lane;
    word_t      half_lane;
    word_t      load_data;
    word_t      wb_data;
    word_t      store_data;
    ctrl_t      ctrl;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       taken;
    logic [1:0] byte_off;
    logic [3:0] byte_en;

    assign imem_addr_o = pc;
    assign retire_pc_o = pc;
    assign pc_plus4    = pc + 32'd4;

    rv_decode decode0 (
        .instr_i (imem_data_i),
        .ctrl_o  (ctrl),
        .imm_o   (imm),
        .rs1_o   (rs1),
        .rs2_o   (rs2),
        .rd_o    (rd)
    );

    rv_regfile regfile0 (
        .clk      (clk),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rd_i     (rd),
        .we_i     (ctrl.reg_write),
        .wdata_i  (wb_data),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    assign alu_a = ctrl.a_is_pc ? pc : rs1_data;
    assign alu_b = ctrl.b_is_imm ? imm : rs2_data;

    rv_alu alu0 (
        .op_i     (ctrl.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .funct_i  (ctrl.branch_funct),
        .result_o (alu_result),
        .taken_o  (taken)
    );

    // ---------------------------------------------------------------------
    // next pc
    // ---------------------------------------------------------------------

    always_comb begin
        if (ctrl.is_jalr) begin
            pc_next = {alu_result[31:1], 1'b0};
        end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
            pc_next = pc + imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // ---------------------------------------------------------------------
    // load and store lanes
    // ---------------------------------------------------------------------

    assign byte_off = alu_result[1:0];

    always_comb begin
        case (ctrl.mem_size)
            BYTE: begin
                byte_en    = 4'b0001 << byte_off;
                store_data = {24'b0, rs2_data[7:0]} << {byte_off, 3'b000};
            end
            HALF: begin
                byte_en    = 4'b0011 << {byte_off[1], 1'b0};
                store_data = {16'b0, rs2_data[15:0]} << {byte_off[1], 4'b0000};
            end
            default: begin
                byte_en    = 4'b1111;
                store_data = rs2_data;
            end
        endcase
    end

    assign byte_lane = dmem_rdata_i >> {byte_off, 3'b000};
    assign half_lane = dmem_rdata_i >> {byte_off[1], 4'b0000};

    always_comb begin
        case (ctrl.mem_size)
            BYTE:    load_data = {{24{!ctrl.mem_unsigned && byte_lane[7]}}, byte_lane[7:0]};
            HALF:    load_data = {{16{!ctrl.mem_unsigned && half_lane[15]}}, half_lane[15:0]};
            default: load_data = dmem_rdata_i;
        endcase
    end

    assign dmem_o = '{write: ctrl.mem_write, waddr: alu_result[31:2],
                      byte_en: byte_en, wdata: store_data};

    assign wb_data = ctrl.wb_link ? pc_plus4 : (ctrl.mem_read ? load_data : alu_result);

    // jump and branch targets must keep fetch on word boundaries
    a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr_o[1:0] == 2'b00);

endmodule

// ==== logic/rv_soc.sv ====
`timescale 1ns/1ps

module rv_soc import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       imem_we_i,    // program load strobe
    input  word_t      imem_addr_i,
    input  word_t      imem_data_i,
    output store_rpt_t store_o,
    output word_t      retire_pc_o
);

    word_t     fetch_addr;
    word_t     fetch_data;
    word_t     dmem_rdata;
    dmem_req_t dmem_req;

    rv_core core0 (
        .clk          (clk),
        .reset        (reset),
        .imem_addr_o  (fetch_addr),
        .imem_data_i  (fetch_data),
        .dmem_o       (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .retire_pc_o  (retire_pc_o)
    );

    rv_mem mem0 (
        .clk          (clk),
        .reset        (reset),
        .imem_we_i    (imem_we_i),
        .imem_waddr_i (imem_addr_i),
        .imem_wdata_i (imem_data_i),
        .imem_addr_i  (fetch_addr),
        .imem_rdata_o (fetch_data),
        .dmem_i       (dmem_req),
        .dmem_rdata_o (dmem_rdata),
        .store_o      (store_o)
    );

endmodule

// ==== sim/tb_rv_soc.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_soc import rv_pkg::*; ();

    localparam int    TIMEOUT_CYCLES = 200;
    localparam word_t DATA_BASE      = 32'h0000_0100;  // result slots based at x10
    localparam word_t LANE_BASE      = 32'h0000_0400;  // lane test word based at x12

    logic       clk;
    logic       reset;
    logic       imem_we;
    word_t      imem_addr;
    word_t      imem_data;
    store_rpt_t store;
    word_t      retire_pc;

    word_t      prog [$];
    store_rpt_t exp_rpt [$];
    int         exp_test [$];
    int         test_errs [0:5] = '{default: 0};
    string      test_names [0:5] = '{"reset state", "alu ops", "x0 writes", "branches",
                                     "jal and jalr", "byte and half lanes"};
    int         cur_test = 0;
    int         slot = 0;
    int         checks = 0;
    int         errors = 0;
    logic       timed_out = 1'b0;
    word_t      ra;
    word_t      rb;

    // {alt, funct3} of add sub sll slt sltu xor srl sra or and
    logic [3:0] alu_ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};  // beq bne blt bge bltu bgeu

    rv_soc dut0 (
        .clk         (clk),
        .reset       (reset),
        .imem_we_i   (imem_we),
        .imem_addr_i (imem_addr),
        .imem_data_i (imem_data),
        .store_o     (store),
        .retire_pc_o (retire_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ---------------------------------------------------------------------
    // instruction encoding and reference rules
    // ---------------------------------------------------------------------

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t next_pc();
        return word_t'(prog.size() * 4);
    endfunction

    // ---------------------------------------------------------------------
    // program and expected store table
    // ---------------------------------------------------------------------

    task automatic expect_store(input store_rpt_t rpt);
        exp_rpt.push_back(rpt);
        exp_test.push_back(cur_test);
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t value);
        word_t hi;
        hi = value + 32'h800;  // addi sign-extends the low part
        prog.push_back({hi[31:12], rd, `RV_OP_LUI});
        prog.push_back(enc_i(value[11:0], rd, 3'b000, rd, `RV_OP_IMM));
    endtask

    task automatic store_result(input reg_addr_t rs, input word_t value, input logic reached);
        store_rpt_t rpt;
        rpt = '{valid: 1'b1, addr: DATA_BASE + word_t'(slot * 4), byte_en: 4'hf, wdata: value};
        prog.push_back(enc_s(12'(slot * 4), rs, 5'd10, 3'b010));
        if (reached) begin
            expect_store(rpt);
        end
        slot++;
    endtask

    task automatic build_program();
        word_t       pc;
        word_t       val;
        word_t       lane_word;
        logic [11:0] imm;
        logic [7:0]  bval;
        logic [15:0] hval;
        logic [2:0]  f3;
        logic        alt;
        store_rpt_t  rpt;

        prog.push_back(enc_i(12'h100, 5'd0, 3'b000, 5'd10, `RV_OP_IMM));
        prog.push_back(enc_i(12'h400, 5'd0, 3'b000, 5'd12, `RV_OP_IMM));
        load_const(5'd1, ra);
        load_const(5'd2, rb);

        cur_test = 1;
        foreach (alu_ops[i]) begin
            f3  = alu_ops[i][2:0];
            alt = alu_ops[i][3];
            prog.push_back(enc_r({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'd3, `RV_OP_REG));
            store_result(5'd3, alu_model(f3, alt, ra, rb), 1'b1);
            if (!(alt && f3 == 3'b000)) begin  // there is no subi
                imm = 12'($urandom());
                if (f3[1:0] == 2'b01) begin
                    imm = {1'b0, alt, 5'b0, imm[4:0]};  // shamt form
                end
                prog.push_back(enc_i(imm, 5'd1, f3, 5'd3, `RV_OP_IMM));
                store_result(5'd3, alu_model(f3, alt, ra, {{20{imm[11]}}, imm}), 1'b1);
            end
        end
        prog.push_back({rb[31:12], 5'd3, `RV_OP_LUI});
        store_result(5'd3, {rb[31:12], 12'b0}, 1'b1);
        pc = next_pc();
        prog.push_back({ra[31:12], 5'd3, `RV_OP_AUIPC});
        store_result(5'd3, pc + {ra[31:12], 12'b0}, 1'b1);

        cur_test = 2;
        prog.push_back(enc_i(12'h05a, 5'd1, 3'b000, 5'd0, `RV_OP_IMM));
        prog.push_back(enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd0, `RV_OP_REG));
        store_result(5'd0, 32'd0, 1'b1);

        cur_test = 3;
        foreach (br_f3[i]) begin
            for (int k = 0; k < 3; k++) begin  // pairs x1/x2, x2/x1, x1/x1
                val = word_t'(16 * i + k + 1);
                prog.push_back(enc_i(val[11:0], 5'd0, 3'b000, 5'd7, `RV_OP_IMM));
                prog.push_back(enc_b(13'd8, (k == 0) ? 5'd2 : 5'd1, (k == 1) ? 5'd2 : 5'd1, br_f3[i]));
                store_result(5'd7, val,
                             !branch_model(br_f3[i], (k == 1) ? rb : ra, (k == 0) ? rb : ra));
            end
        end

        cur_test = 4;
        pc = next_pc();
        prog.push_back(enc_j(21'd8, 5'd8));
        store_result(5'd0, 32'd0, 1'b0);  // jumped over
        store_result(5'd8, pc + 32'd4, 1'b1);
        pc = next_pc();
        prog.push_back(enc_i(12'(pc + 32'd12), 5'd0, 3'b000, 5'd9, `RV_OP_IMM));
        prog.push_back(enc_i(12'h001, 5'd9, 3'b000, 5'd11, `RV_OP_JALR));  // odd target
        store_result(5'd0, 32'd0, 1'b0);
        store_result(5'd11, pc + 32'd8, 1'b1);

        cur_test = 5;
        lane_word = '0;
        rpt.valid = 1'b1;
        rpt.addr  = LANE_BASE;
        for (int k = 0; k < 4; k++) begin
            val = k[0] ? rb : ra;
            prog.push_back(enc_s(12'(k), k[0] ? 5'd2 : 5'd1, 5'd12, 3'b000));
            rpt.byte_en = 4'(1 << k);
            rpt.wdata   = word_t'(val[7:0]) << (8 * k);
            expect_store(rpt);
            lane_word[8*k +: 8] = val[7:0];
        end
        for (int k = 0; k < 4; k++) begin
            bval = lane_word[8*k +: 8];
            prog.push_back(enc_i(12'(k), 5'd12, 3'b000, 5'd13, `RV_OP_LOAD));  // lb
            store_result(5'd13, {{24{bval[7]}}, bval}, 1'b1);
            prog.push_back(enc_i(12'(k), 5'd12, 3'b100, 5'd13, `RV_OP_LOAD));  // lbu
            store_result(5'd13, {24'b0, bval}, 1'b1);
        end
        for (int h = 0; h < 2; h++) begin
            val = h[0] ? rb : ra;
            prog.push_back(enc_s(12'(2 * h), h[0] ? 5'd2 : 5'd1, 5'd12, 3'b001));
            rpt.byte_en = 4'(3 << (2 * h));
            rpt.wdata   = word_t'(val[15:0]) << (16 * h);
            expect_store(rpt);
            lane_word[16*h +: 16] = val[15:0];
        end
        for (int h = 0; h < 2; h++) begin
            hval = lane_word[16*h +: 16];
            prog.push_back(enc_i(12'(2 * h), 5'd12, 3'b001, 5'd13, `RV_OP_LOAD));  // lh
            store_result(5'd13, {{16{hval[15]}}, hval}, 1'b1);
            prog.push_back(enc_i(12'(2 * h), 5'd12, 3'b101, 5'd13, `RV_OP_LOAD));  // lhu
            store_result(5'd13, {16'b0, hval}, 1'b1);
        end
        prog.push_back(enc_j(21'd0, 5'd0));  // park on a self loop
    endtask

    // ---------------------------------------------------------------------
    // checks and reporting
    // ---------------------------------------------------------------------

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s got %08h expected %08h", name, got, exp);
            errors++;
            test_errs[cur_test]++;
        end
    endtask

    task automatic check_store(input store_rpt_t got, input store_rpt_t exp);
        check_word("store_o.addr", got.addr, exp.addr);
        check_word("store_o.wdata", got.wdata, exp.wdata);
        checks++;
        if (got.byte_en !== exp.byte_en) begin
            $display("ERROR store_o.byte_en got %h expected %h", got.byte_en, exp.byte_en);
            errors++;
            test_errs[cur_test]++;
        end
    endtask

    task automatic wait_store(input int index);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!store.valid && cycles < TIMEOUT_CYCLES);
        if (!store.valid) begin
            $display("no store report arrived within %0d cycles for expected store %0d",
                     TIMEOUT_CYCLES, index);
            timed_out = 1'b1;
            errors++;
            test_errs[cur_test]++;
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %s", t, test_names[t], (test_errs[t] == 0) ? "ok" : "fail");
    endtask

    initial begin
        void'($urandom(68155));
        reset     = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        ra = $urandom() | 32'h8000_8080;  // negative with the low byte and half also negative
        rb = $urandom() & 32'h7fff_7f7f;  // positive with those sign bits clear
        build_program();

        foreach (prog[i]) begin  // program load while reset is held
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = word_t'(i * 4);
            imem_data = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (10) @(negedge clk);
        cur_test = 0;
        check_word("retire_pc_o", retire_pc, `RV_RESET_PC);
        check_word("store_o.valid", word_t'(store.valid), 32'd0);
        report_test(0);
        reset = 1'b0;

        foreach (exp_rpt[n]) begin
            if (!timed_out) begin
                cur_test = exp_test[n];
                wait_store(n);
                if (!timed_out) begin
                    check_store(store, exp_rpt[n]);
                end
                if (timed_out || n == exp_rpt.size() - 1 || exp_test[n + 1] != cur_test) begin
                    report_test(cur_test);
                end
            end
        end

        if (!timed_out) begin
            repeat (20) begin  // no store may follow once the core is parked
                @(negedge clk);
                if (store.valid) begin
                    $display("unexpected store report to %08h after the last expected one",
                             store.addr);
                    errors++;
                end
            end
            // parked on the last word, an odd jalr target would leave pc off by one
            check_word("retire_pc_o", retire_pc, word_t'((prog.size() - 1) * 4));
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_mem.sv
logic/rv_core.sv
logic/rv_soc.sv
sim/tb_rv_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the RV32I SoC testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_rv_soc -f src.f -o tb_rv_soc_sim
./obj_dir/tb_rv_soc_sim | tee sim.log

grep -qx "TB PASSED" sim.log
